// File: files.f
+incdir+design
design/rv_isa_pkg.sv
design/alu_pkg.sv
design/approx_adder_block.sv
design/approx_adder.sv
design/alu_decode.sv
design/alu_execute.sv
design/alu_result.sv
design/alu_top.sv
verification/alu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the ALU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f files.f \
    --top-module alu_tb \
    --Mdir obj_dir \
    -o alu_tb_sim

./obj_dir/alu_tb_sim > sim.log
cat sim.log

if grep -qx "Finished with no errors" sim.log; then
    echo "Simulation PASSED"
else
    echo "Simulation FAILED"
    exit 1
fi

// File: verification/alu_tb.sv
// ----------------------------------------------------------------------
// Testbench for the two-stage approximate RV32I ALU
// Inputs change on the falling edge, outputs are checked on the falling edge
// Expected values come from alu_ref, a bit-level model of the adder rule
// Latency is checked as exactly 2 rising edges per request
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`include "alu_macros.svh"

module alu_tb;
    import alu_pkg::*;
    import rv_isa_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int RST_CYCLES = 5;
    localparam int N_ACC      = 40;
    localparam int N_APX      = 60;
    localparam int N_LOGIC    = 60;
    localparam int N_JUMP     = 30;
    localparam int N_ILL      = 30;
    localparam int N_MIX      = 40;
    localparam int MAX_GAP    = 2;     // Idle cycles between mixed requests
    localparam int NUM_TESTS  = 6;
    localparam int TOTAL_REQ  = N_ACC + N_APX + N_LOGIC + N_JUMP + N_ILL + N_MIX;
    localparam int WD_CYCLES  = TOTAL_REQ + N_MIX * MAX_GAP + RST_CYCLES +
                                4 * NUM_TESTS + 20;

    // Request kinds
    localparam int K_ADD   = 0;        // ADD, SUB, ADDI
    localparam int K_LOGIC = 1;        // Logic, compare, shift
    localparam int K_JUMP  = 2;        // JAL, JALR, AUIPC
    localparam int K_ILL   = 3;        // Illegal encodings
    localparam int K_ANY   = -1;

    logic      clk;
    logic      rst_n;
    logic      in_valid;
    alu_req_t  in_req;
    apx_csr_t  in_csr;
    logic      out_valid;
    alu_resp_t out_resp;

    int        seed     = 74801;
    int        edge_cnt = 0;           // Rising edges seen so far
    int        err_cnt  = 0;
    int        chk_cnt  = 0;
    int        test_cnt = 0;
    alu_resp_t exp_q[$];               // Expected responses in issue order
    string     name_q[$];
    int        edge_q[$];              // Edge that samples each request

    alu_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .in_csr    (in_csr),
        .out_valid (out_valid),
        .out_resp  (out_resp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) edge_cnt <= edge_cnt + 1;

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------
    // Full adder, approximate when exact is 0; returns {carry, sum}
    function automatic logic [1:0] model_fa(input logic exact, input logic x,
                                            input logic y, input logic c);
        if (exact)
            return {(x & y) | (x & c) | (y & c), x ^ y ^ c};
        return {x & (y | c), (x ^ y) | c};
    endfunction

    function automatic logic [31:0] model_add(input logic [31:0] a, input logic [31:0] b,
                                              input logic cin,
                                              input logic [`ALU_APX_LEN-1:0] msk);
        logic [31:0] s;
        logic [3:0]  t;
        logic [1:0]  fa;
        logic        c;
        logic        rc;
        logic        e;
        c = cin;
        s = '0;
        for (int i = 0; i < `ALU_XLEN; i += `ALU_BLOCK_W) begin
            if (i == 0) begin
                for (int k = 0; k < 4; k++) begin      // Plain ripple with cin
                    fa   = model_fa(msk[k], a[k], b[k], c);
                    s[k] = fa[0];
                    c    = fa[1];
                end
            end else begin
                t[0] = a[i] ^ b[i];                    // Half adder
                rc   = a[i] & b[i];
                for (int k = 1; k < 4; k++) begin
                    e = 1'b1;
                    if (i < `ALU_APX_LEN)
                        e = msk[i+k];
                    fa   = model_fa(e, a[i+k], b[i+k], rc);
                    t[k] = fa[0];
                    rc   = fa[1];
                end
                if (c) begin                           // Block carry selects t+1
                    s[i +: 4] = t + 4'd1;
                    c         = rc | (&t);
                end else begin
                    s[i +: 4] = t;
                    c         = rc;
                end
            end
        end
        return s;
    endfunction

    function automatic alu_resp_t alu_ref(input alu_req_t req, input apx_csr_t csr);
        alu_resp_t               r;
        logic [31:0]             a;
        logic [31:0]             b;
        logic [4:0]              sh;
        logic [`ALU_APX_LEN-1:0] msk;
        logic                    base;
        logic                    alt;
        r    = '0;
        a    = req.rs1;
        b    = (req.opcode == OP_IMM) ? req.imm : req.rs2;
        sh   = b[4:0];
        base = (req.funct7 == F7_BASE);
        alt  = (req.funct7 == F7_ALT);
        msk  = csr.err_ctl[`ALU_APX_LEN-1:0];
        case (req.opcode)
            OP, OP_IMM: begin
                if (req.opcode == OP)
                    r.illegal = !(base || (alt && (req.funct3 == F3_ADD_SUB ||
                                                   req.funct3 == F3_SRL_SRA)));
                else
                    r.illegal = (req.funct3 == F3_SLL && !base) ||
                                (req.funct3 == F3_SRL_SRA && !base && !alt);
                case (req.funct3)
                    F3_ADD_SUB: begin
                        // Accurate mode is plain two's complement arithmetic
                        if (req.opcode == OP && alt)
                            r.result = csr.approx_en ? model_add(a, ~b, 1'b1, msk) : a - b;
                        else
                            r.result = csr.approx_en ? model_add(a, b, 1'b0, msk) : a + b;
                    end
                    F3_SLL:  r.result = a << sh;
                    F3_SLT:  r.result = {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};
                    F3_SLTU: r.result = {31'b0, a < b};
                    F3_XOR:  r.result = a ^ b;
                    F3_SRL_SRA: begin
                        r.result = a >> sh;
                        if (alt && a[31])                  // Fill vacated bits with sign
                            r.result = r.result | ~(32'hffff_ffff >> sh);
                    end
                    F3_OR:   r.result = a | b;
                    default: r.result = a & b;
                endcase
            end
            JAL:     r.result = req.pc + 32'd4;
            JALR: begin
                r.illegal = (req.funct3 != F3_JALR);
                r.result  = req.pc + 32'd4;
            end
            AUIPC:   r.result = req.pc + req.imm;
            default: r.illegal = 1'b1;
        endcase
        if (r.illegal)
            r.result = '0;
        return r;
    endfunction

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------
    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    task automatic gen_req(input int kind, output alu_req_t req);
        logic [31:0] r;
        r          = rand_word();
        req.pc     = rand_word() & 32'hffff_fffc;
        req.rs1    = rand_word();
        req.rs2    = rand_word();
        req.imm    = {{20{r[31]}}, r[31:20]};          // Sign-extended I immediate
        req.funct3 = r[2:0];
        req.funct7 = F7_BASE;
        req.opcode = OP;
        case (kind)
            K_ADD: begin
                req.funct3 = F3_ADD_SUB;
                if (r[4:3] == 2'd1)
                    req.funct7 = F7_ALT;                 // SUB
                else if (r[4:3] != 2'd0) begin
                    req.opcode = OP_IMM;                 // ADDI
                    req.funct7 = r[11:5];
                end
            end
            K_LOGIC: begin
                if (req.funct3 == F3_ADD_SUB)
                    req.funct3 = F3_SRL_SRA;             // Extra shift coverage
                if (req.funct3 == F3_SRL_SRA && r[4])
                    req.funct7 = F7_ALT;                 // SRA, SRAI
                if (!r[3]) begin
                    req.opcode = OP_IMM;
                    if (req.funct3 != F3_SLL && req.funct3 != F3_SRL_SRA)
                        req.funct7 = r[11:5];            // Part of the immediate
                end
            end
            K_JUMP: begin
                case (r[4:3])
                    2'd0: req.opcode = JAL;
                    2'd1: begin
                        req.opcode = JALR;
                        req.funct3 = F3_JALR;
                    end
                    default: begin
                        req.opcode = AUIPC;
                        req.imm    = {r[31:12], 12'b0};
                    end
                endcase
            end
            default: begin
                case (r[4:3])
                    2'd0: req.funct7 = {r[11:6], 1'b1};  // Neither base nor alternate
                    2'd1: begin
                        req.funct7 = F7_ALT;             // Alternate on wrong funct3
                        if (req.funct3 == F3_ADD_SUB || req.funct3 == F3_SRL_SRA)
                            req.funct3 = req.funct3 ^ 3'b010;
                    end
                    2'd2: begin
                        req.opcode = JALR;
                        req.funct3 = (r[2:0] == 3'b000) ? 3'b100 : r[2:0];
                    end
                    default: begin
                        case (r[6:5])                    // LOAD, STORE, BRANCH, LUI
                            2'd0:    req.opcode = 7'b0000011;
                            2'd1:    req.opcode = 7'b0100011;
                            2'd2:    req.opcode = 7'b1100011;
                            default: req.opcode = 7'b0110111;
                        endcase
                    end
                endcase
            end
        endcase
    endtask

    task automatic send_req(input string name, input alu_req_t req, input apx_csr_t csr);
        @(negedge clk);
        in_valid = 1'b1;
        in_req   = req;
        in_csr   = csr;
        exp_q.push_back(alu_ref(req, csr));
        name_q.push_back(name);
        edge_q.push_back(edge_cnt + 1);                 // Sampled at the next rising edge
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    // apx_mode 0 accurate, 1 approximate, 2 random
    task automatic run_test(input string name, input int kind, input int count,
                            input int apx_mode, input int max_gap);
        alu_req_t req;
        apx_csr_t csr;
        int       err_before;
        int       k;
        int       gap;
        err_before = err_cnt;
        for (int n = 0; n < count; n++) begin
            k = (kind == K_ANY) ? int'(rand_word() % 4) : kind;
            gen_req(k, req);
            csr = rand_word();
            if (apx_mode != 2)
                csr.approx_en = (apx_mode == 1);
            send_req(name, req, csr);
            gap = int'(rand_word() % (max_gap + 1));
            repeat (gap) idle_cycle();
        end
        idle_cycle();
        while (exp_q.size() != 0) @(posedge clk);       // Wait for the last response
        test_cnt++;
        $display("test %-14s %0d requests, %0d errors", name, count, err_cnt - err_before);
    endtask

    // ------------------------------------------------------------------
    // Response comparison
    // ------------------------------------------------------------------
    always @(negedge clk) begin : compare_resp
        alu_resp_t exp_resp;
        string     exp_name;
        int        issue_edge;
        if (rst_n && out_valid) begin
            assert (exp_q.size() != 0) else begin
                $display("ERROR: out_valid pulsed with no request outstanding");
                err_cnt++;
            end
            if (exp_q.size() != 0) begin
                exp_resp   = exp_q.pop_front();
                exp_name   = name_q.pop_front();
                issue_edge = edge_q.pop_front();
                chk_cnt++;
                assert (out_resp.result == exp_resp.result) else begin
                    $display("CHECK FAILED %s result: expected %08h, actual %08h",
                             exp_name, exp_resp.result, out_resp.result);
                    err_cnt++;
                end
                assert (out_resp.illegal == exp_resp.illegal) else begin
                    $display("CHECK FAILED %s illegal: expected %0b, actual %0b",
                             exp_name, exp_resp.illegal, out_resp.illegal);
                    err_cnt++;
                end
                assert (edge_cnt == issue_edge + 1) else begin
                    $display("ERROR: %s response came %0d edges after the request, not 2",
                             exp_name, edge_cnt - issue_edge + 1);
                    err_cnt++;
                end
            end
        end
    end

    initial begin : watchdog
        #(WD_CYCLES * CLK_PERIOD);
        $display("ERROR: run timed out with %0d responses outstanding", exp_q.size());
        $display("Finished with errors");
        $finish;
    end

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin : main
        in_valid = 1'b0;
        in_req   = '0;
        in_csr   = '0;
        rst_n    = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        assert (out_valid == 1'b0 && out_resp == '0) else begin
            $display("ERROR: outputs not cleared by reset");
            err_cnt++;
        end
        test_cnt++;
        $display("test %-14s %0d errors", "reset_state", err_cnt);
        rst_n = 1'b1;

        run_test("accurate_add", K_ADD,   N_ACC,   0, 0);
        run_test("approx_add",   K_ADD,   N_APX,   1, 0);
        run_test("logic_shift",  K_LOGIC, N_LOGIC, 2, 0);
        run_test("jump_auipc",   K_JUMP,  N_JUMP,  2, 0);
        run_test("illegal",      K_ILL,   N_ILL,   2, 0);
        run_test("mixed_stream", K_ANY,   N_MIX,   2, MAX_GAP);

        $display("tests: %0d, checks: %0d, errors: %0d", test_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: design/alu_top.sv
// ----------------------------------------------------------------------
// Two-stage RV32I ALU with approximate adder
// Latency 2 clock edges from in_valid to out_valid, no back-pressure
// A new request may be issued every cycle
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module alu_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  alu_pkg::alu_req_t  in_req,
    input  alu_pkg::apx_csr_t  in_csr,
    output logic               out_valid,
    output alu_pkg::alu_resp_t out_resp
);
    import alu_pkg::*;

    logic     dec_valid;
    alu_dec_t dec;             // Stage 1 register
    alu_exe_t exe;             // Combinational execute result

    alu_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .in_csr    (in_csr),
        .dec_valid (dec_valid),
        .dec       (dec)
    );

    alu_execute u_execute (
        .dec (dec),
        .exe (exe)
    );

    alu_result u_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .exe_valid (dec_valid),  // Execute adds no latency
        .exe       (exe),
        .out_valid (out_valid),
        .out_resp  (out_resp)
    );

endmodule

// File: design/alu_result.sv
// ----------------------------------------------------------------------
// Stage 2: result select and output register
// Illegal requests return a zero result with illegal set
// out_resp holds its last value between strobes
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module alu_result (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               exe_valid,
    input  alu_pkg::alu_exe_t  exe,
    output logic               out_valid,
    output alu_pkg::alu_resp_t out_resp
);
    import alu_pkg::*;

    alu_resp_t resp_d;

    always_comb begin
        resp_d.illegal = exe.illegal;
        if (exe.illegal) begin
            resp_d.result = '0;                    // No floating output
        end else begin
            resp_d.result = exe.use_sum ? exe.sum : exe.logic_res;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_resp  <= '0;
        end else begin
            out_valid <= exe_valid;                // One-cycle strobe
            if (exe_valid) begin
                out_resp <= resp_d;
            end
        end
    end

endmodule

// File: design/alu_execute.sv
// ----------------------------------------------------------------------
// Execute stage, purely combinational
// ADDI, ADD and SUB use the approximate adder, all else is exact
// R-type and I-type shifts use the low 5 bits of op_b
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`include "alu_macros.svh"

module alu_execute (
    input  alu_pkg::alu_dec_t dec,
    output alu_pkg::alu_exe_t exe
);
    import alu_pkg::*;

    localparam int SHAMT_W = $clog2(`ALU_XLEN);

    logic [`ALU_XLEN-1:0] add_b;         // op_b, inverted for SUB
    logic [`ALU_XLEN-1:0] add_sum;
    logic [SHAMT_W-1:0]   shamt;

    assign add_b = dec.sub_en ? ~dec.op_b : dec.op_b;
    assign shamt = dec.op_b[SHAMT_W-1:0];

    approx_adder #(
        .APX_LEN (`ALU_APX_LEN)
    ) u_adder (
        .a       (dec.op_a),
        .b       (add_b),
        .cin     (dec.sub_en),           // Two's complement +1
        .er_mask (dec.er_mask),
        .sum     (add_sum)
    );

    // ------------------------------------------------------------------
    // Logic, compare, shift and exact add
    // ------------------------------------------------------------------
    always_comb begin
        exe.sum     = add_sum;
        exe.illegal = dec.illegal;
        exe.use_sum = (dec.op == OP_ADDI) || (dec.op == OP_ADD) ||
                      (dec.op == OP_SUB);
        case (dec.op)
            OP_SLL, OP_SLLI:
                exe.logic_res = dec.op_a << shamt;
            OP_SRL, OP_SRLI:
                exe.logic_res = dec.op_a >> shamt;
            OP_SRA, OP_SRAI:
                exe.logic_res = $signed(dec.op_a) >>> shamt; // Sign fill
            OP_SLT, OP_SLTI:
                exe.logic_res = {{(`ALU_XLEN-1){1'b0}},
                                 $signed(dec.op_a) < $signed(dec.op_b)};
            OP_SLTU, OP_SLTIU:
                exe.logic_res = {{(`ALU_XLEN-1){1'b0}}, dec.op_a < dec.op_b};
            OP_XOR, OP_XORI:
                exe.logic_res = dec.op_a ^ dec.op_b;
            OP_OR, OP_ORI:
                exe.logic_res = dec.op_a | dec.op_b;
            OP_AND, OP_ANDI:
                exe.logic_res = dec.op_a & dec.op_b;
            OP_JAL, OP_JALR, OP_AUIPC:
                exe.logic_res = dec.op_a + dec.op_b;         // Exact pc add
            default:
                exe.logic_res = '0;                          // Adder ops, illegal
        endcase
    end

endmodule

// File: design/alu_decode.sv
// ----------------------------------------------------------------------
// Stage 1: instruction decode, operand select, error mask
// Payload is captured only on in_valid, dec_valid is a 1-cycle strobe
// Unsupported encodings decode to OP_ILLEGAL with illegal set
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`include "alu_macros.svh"

module alu_decode (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  alu_pkg::alu_req_t  in_req,
    input  alu_pkg::apx_csr_t  in_csr,
    output logic               dec_valid,
    output alu_pkg::alu_dec_t  dec
);
    import alu_pkg::*;
    import rv_isa_pkg::*;

    alu_dec_t dec_d;
    logic     f7_base;
    logic     f7_alt;

    assign f7_base = (in_req.funct7 == F7_BASE);
    assign f7_alt  = (in_req.funct7 == F7_ALT);

    // ------------------------------------------------------------------
    // Operation and operand decode
    // ------------------------------------------------------------------
    always_comb begin
        dec_d.op   = OP_ILLEGAL;
        dec_d.op_a = in_req.rs1;                           // Default R-type
        dec_d.op_b = in_req.rs2;
        case (in_req.opcode)
            OP: begin
                case (in_req.funct3)
                    F3_ADD_SUB: dec_d.op = f7_alt ? OP_SUB : OP_ADD;
                    F3_SLL:     dec_d.op = OP_SLL;
                    F3_SLT:     dec_d.op = OP_SLT;
                    F3_SLTU:    dec_d.op = OP_SLTU;
                    F3_XOR:     dec_d.op = OP_XOR;
                    F3_SRL_SRA: dec_d.op = f7_alt ? OP_SRA : OP_SRL;
                    F3_OR:      dec_d.op = OP_OR;
                    default:    dec_d.op = OP_AND;
                endcase
                // Alternate funct7 only valid for SUB and SRA
                if (!f7_base && !(f7_alt && (in_req.funct3 == F3_ADD_SUB ||
                                             in_req.funct3 == F3_SRL_SRA)))
                    dec_d.op = OP_ILLEGAL;
            end
            OP_IMM: begin
                dec_d.op_b = in_req.imm;
                case (in_req.funct3)
                    F3_ADD_SUB: dec_d.op = OP_ADDI;
                    F3_SLL:     dec_d.op = f7_base ? OP_SLLI : OP_ILLEGAL;
                    F3_SLT:     dec_d.op = OP_SLTI;
                    F3_SLTU:    dec_d.op = OP_SLTIU;
                    F3_XOR:     dec_d.op = OP_XORI;
                    F3_SRL_SRA: dec_d.op = f7_base ? OP_SRLI :
                                           f7_alt  ? OP_SRAI : OP_ILLEGAL;
                    F3_OR:      dec_d.op = OP_ORI;
                    default:    dec_d.op = OP_ANDI;
                endcase
            end
            JAL: begin
                dec_d.op   = OP_JAL;
                dec_d.op_a = in_req.pc;                    // Link address pc+4
                dec_d.op_b = `ALU_XLEN'd4;
            end
            JALR: begin
                dec_d.op   = (in_req.funct3 == F3_JALR) ? OP_JALR : OP_ILLEGAL;
                dec_d.op_a = in_req.pc;
                dec_d.op_b = `ALU_XLEN'd4;
            end
            AUIPC: begin
                dec_d.op   = OP_AUIPC;
                dec_d.op_a = in_req.pc;
                dec_d.op_b = in_req.imm;
            end
            default: dec_d.op = OP_ILLEGAL;                // Not an ALU opcode
        endcase

        dec_d.sub_en  = (dec_d.op == OP_SUB);
        dec_d.illegal = (dec_d.op == OP_ILLEGAL);
        // Accurate mode forces every FA exact
        dec_d.er_mask = in_csr.err_ctl[`ALU_APX_LEN-1:0] |
                        {`ALU_APX_LEN{~in_csr.approx_en}};
    end

    // ------------------------------------------------------------------
    // Stage 1 register
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= in_valid;                         // One-cycle strobe
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            dec <= dec_d;                                  // Payload, no reset
        end
    end

endmodule

// File: design/approx_adder.sv
// ----------------------------------------------------------------------
// Accuracy-controllable adder built from 4-bit carry-select blocks
// Blocks below APX_LEN are error-configurable, the rest are exact
// APX_LEN must be a multiple of 4 and at least 4
// No carry-out is provided
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`include "alu_macros.svh"

module approx_adder #(
    parameter int APX_LEN = `ALU_APX_LEN
) (
    input  logic [`ALU_XLEN-1:0] a,
    input  logic [`ALU_XLEN-1:0] b,
    input  logic                 cin,
    input  logic [APX_LEN-1:0]   er_mask,  // 1 = exact FA
    output logic [`ALU_XLEN-1:0] sum
);
    localparam int NUM_BLK = `ALU_XLEN / `ALU_BLOCK_W;

    logic [NUM_BLK:0] carry;                // carry[k] feeds block k

    assign carry[0] = cin;

    for (genvar blk = 0; blk < NUM_BLK; blk++) begin : g_blk
        localparam int LO     = blk * `ALU_BLOCK_W;
        localparam bit IS_APX = (LO < APX_LEN);

        logic [`ALU_BLOCK_W-1:0] er_blk;

        if (IS_APX) begin : g_apx
            assign er_blk = er_mask[LO +: `ALU_BLOCK_W];
        end else begin : g_exact
            assign er_blk = '1;              // Exact region
        end

        approx_adder_block #(
            .APPROX (IS_APX),
            .FIRST  (blk == 0)               // Plain ripple for bits 3:0
        ) u_blk (
            .a    (a[LO +: `ALU_BLOCK_W]),
            .b    (b[LO +: `ALU_BLOCK_W]),
            .cin  (carry[blk]),
            .er   (er_blk),
            .sum  (sum[LO +: `ALU_BLOCK_W]),
            .cout (carry[blk+1])
        );
    end

endmodule

// File: design/approx_adder_block.sv
// ----------------------------------------------------------------------
// One 4-bit adder block, error-configurable or exact
// FIRST=1: 4-bit ripple of error-configurable FAs with carry-in cin
// FIRST=0: half adder plus 3-bit ripple with carry-in 0, then +1 and
// a carry-select mux driven by cin
// er bit = 0 turns that FA approximate, er is ignored when APPROX=0
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`include "alu_macros.svh"

module approx_adder_block #(
    parameter bit APPROX = 1'b1,
    parameter bit FIRST  = 1'b0
) (
    input  logic [`ALU_BLOCK_W-1:0] a,
    input  logic [`ALU_BLOCK_W-1:0] b,
    input  logic                    cin,
    input  logic [`ALU_BLOCK_W-1:0] er,
    output logic [`ALU_BLOCK_W-1:0] sum,
    output logic                    cout
);
    logic [`ALU_BLOCK_W-1:0] msk;        // Effective FA mask
    logic [`ALU_BLOCK_W-1:0] tent;       // Tentative sum
    logic [`ALU_BLOCK_W:0]   rc;         // Ripple carries
    logic [`ALU_BLOCK_W-1:0] tent_inc;   // Tentative sum + 1
    logic                    sel;

    // Error-configurable FA, returns {carry, sum}
    function automatic logic [1:0] ecfa(input logic e, input logic x,
                                        input logic y, input logic c);
        logic s;
        logic co;
        s  = e ? (x ^ y ^ c) : ((x ^ y) | c);
        co = e ? ((x & y) | (x & c) | (y & c)) : (x & (y | c));
        return {co, s};
    endfunction

    assign msk = APPROX ? er : '1;

    // ------------------------------------------------------------------
    // Ripple section
    // ------------------------------------------------------------------
    always_comb begin
        rc[0] = FIRST ? cin : 1'b0;      // Select blocks assume carry 0
        for (int k = 0; k < `ALU_BLOCK_W; k++) begin
            if (k == 0 && !FIRST) begin
                tent[0] = a[0] ^ b[0];   // Half adder
                rc[1]   = a[0] & b[0];
            end else begin
                {rc[k+1], tent[k]} = ecfa(msk[k], a[k], b[k], rc[k]);
            end
        end
    end

    // ------------------------------------------------------------------
    // Increment unit and carry select
    // ------------------------------------------------------------------
    assign tent_inc = tent + 1'b1;                 // Wraps mod 16
    assign sel      = FIRST ? 1'b0 : cin;          // First block already took cin
    assign sum      = sel ? tent_inc : tent;
    assign cout     = sel ? (rc[`ALU_BLOCK_W] | (&tent)) : rc[`ALU_BLOCK_W];

endmodule

// File: design/alu_pkg.sv
// ----------------------------------------------------------------------
// ALU internal types: operations, approximation CSR, stage payloads
// CSR circuit_sel is reserved and ignored, only one adder exists
// er_mask width follows ALU_APX_LEN
// ----------------------------------------------------------------------
`include "alu_macros.svh"

package alu_pkg;

    // One entry per executed instruction
    typedef enum logic [4:0] {
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI, OP_SRAI,
        OP_ADD,  OP_SUB,  OP_SLL,   OP_SLT,  OP_SLTU, OP_XOR,
        OP_SRL,  OP_SRA,  OP_OR,    OP_AND,
        OP_JAL,  OP_JALR, OP_AUIPC,
        OP_ILLEGAL
    } alu_op_e;

    // Approximation CSR, bit 0 is approx_en
    typedef struct packed {
        logic [`ALU_XLEN-`ALU_CSR_ER_LSB-1:0]       err_ctl;      // Per-bit FA mask
        logic [`ALU_CSR_ER_LSB-`ALU_CSR_APX_BIT-2:0] circuit_sel; // Reserved
        logic                                        approx_en;   // 1 = approximate
    } apx_csr_t;

    // Request from the decoder/register file
    typedef struct packed {
        logic [6:0]           opcode;   // Raw, may hold unsupported codes
        logic [2:0]           funct3;
        logic [6:0]           funct7;
        logic [`ALU_XLEN-1:0] pc;
        logic [`ALU_XLEN-1:0] rs1;
        logic [`ALU_XLEN-1:0] rs2;
        logic [`ALU_XLEN-1:0] imm;
    } alu_req_t;

    // Stage 1 register contents
    typedef struct packed {
        alu_op_e                 op;
        logic [`ALU_XLEN-1:0]    op_a;
        logic [`ALU_XLEN-1:0]    op_b;
        logic                    sub_en;   // Invert op_b, carry in 1
        logic [`ALU_APX_LEN-1:0] er_mask;  // 1 = exact FA
        logic                    illegal;
    } alu_dec_t;

    // Execute results before the output mux
    typedef struct packed {
        logic                 use_sum;    // ADDI, ADD, SUB
        logic [`ALU_XLEN-1:0] sum;
        logic [`ALU_XLEN-1:0] logic_res;
        logic                 illegal;
    } alu_exe_t;

    // Registered response
    typedef struct packed {
        logic [`ALU_XLEN-1:0] result;
        logic                 illegal;
    } alu_resp_t;

endpackage

// File: design/rv_isa_pkg.sv
// ----------------------------------------------------------------------
// RV32I encodings used by the ALU
// Only the opcodes the ALU executes are listed
// ----------------------------------------------------------------------
package rv_isa_pkg;

    // Major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OP     = 7'b01_100_11,  // R-type arithmetic
        OP_IMM = 7'b00_100_11,  // I-type arithmetic
        JAL    = 7'b11_011_11,
        JALR   = 7'b11_001_11,
        AUIPC  = 7'b00_101_11
    } rv_opcode_e;

    // funct3 values
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_JALR    = 3'b000;   // Only legal JALR funct3

    // funct7 values
    localparam logic [6:0] F7_BASE    = 7'b0_000_000;
    localparam logic [6:0] F7_ALT     = 7'b0_100_000;  // SUB, SRA, SRAI

endpackage

// File: design/alu_macros.svh
// ----------------------------------------------------------------------
// Shared widths and CSR field positions for the approximate ALU
// ALU_APX_LEN must be a multiple of ALU_BLOCK_W and at least one block
// Block width is fixed at 4 by the carry-select block structure
// ----------------------------------------------------------------------
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

`define ALU_XLEN        32  // Datapath width
`define ALU_APX_LEN     8   // Approximate low bits, multiple of 4
`define ALU_BLOCK_W     4   // Carry-select block width

// Approximation CSR layout
`define ALU_CSR_APX_BIT 0   // Approximate enable
`define ALU_CSR_ER_LSB  3   // First error-control bit

`endif
